// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // Basic data widths of the memory front end
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Four byte lanes per port, so two offset bits per byte address
  localparam int N_LANES     = 4;
  localparam int OFFSET_BITS = 2;

  // Lane number, also the byte offset inside a word
  typedef logic [OFFSET_BITS-1:0] lane_idx_t;

  // Store control code as issued by the core
  // Any code not listed here means no write
  typedef enum logic [2:0] {
    store_none = 3'd0,
    store_byte = 3'd1,
    store_half = 3'd2,
    store_word = 3'd4
  } store_kind_e;

  // Request of one port, sampled on every enabled rising edge
  typedef struct packed {
    logic        en;
    store_kind_e kind;
    addr_t       addr;
    word_t       wdata;
  } mem_req_t;

  // Request seen by one byte lane
  // word_addr is kept at full width and truncated inside the RAM
  typedef struct packed {
    addr_t word_addr;
    byte_t wdata;
    logic  we;
  } lane_req_t;

  // Rotate a lane mask towards higher lanes, wrapping lane 3 into lane 0
  function automatic logic [N_LANES-1:0] rotl_mask(
    input logic [N_LANES-1:0] mask,
    input lane_idx_t          sh
  );
    logic [2*N_LANES-1:0] dbl;
    dbl = {mask, mask} << sh;
    return dbl[2*N_LANES-1:N_LANES];
  endfunction

endpackage

// ==== logic/byte_lane_ram.sv ====
`timescale 1ns/100ps

module byte_lane_ram
  import mem_pkg::*;
#(
  parameter int WORD_ADDR_BITS = 10
) (
  input  logic      clk_1,
  input  logic      en,
  input  lane_req_t req,
  output byte_t     rdata
);

  localparam int DEPTH = 2 ** WORD_ADDR_BITS;

  // Storage for one byte of every word in the bank
  byte_t mem [DEPTH];

  // Word address wraps modulo the depth
  logic [WORD_ADDR_BITS-1:0] idx;

  assign idx = req.word_addr[WORD_ADDR_BITS-1:0];

  // Read-first port
  // The old byte goes to rdata at the same edge that commits the write
  always_ff @(posedge clk_1) begin
    if (en) begin
      rdata <= mem[idx];
    end
  end

  always_ff @(posedge clk_1) begin
    if (en && req.we) begin
      mem[idx] <= req.wdata;
    end
  end

  // rdata holds its value while en is low, since neither block fires

endmodule

// ==== logic/lane_request_gen.sv ====
`timescale 1ns/100ps

module lane_request_gen
  import mem_pkg::*;
(
  input  mem_req_t                 req,
  output lane_req_t [N_LANES-1:0] lanes
);

  // Word address of the request and the word after it
  addr_t base_word;
  addr_t next_word;

  // Byte offset of the request inside its word
  lane_idx_t offset;

  // Store data viewed as bytes, byte 0 in the low bits
  byte_t [N_LANES-1:0] wbytes;

  // Per-lane results
  addr_t [N_LANES-1:0] lane_addr;
  byte_t [N_LANES-1:0] lane_wdata;

  // Write mask before and after placement at the offset
  logic [N_LANES-1:0] kind_mask;
  logic [N_LANES-1:0] we_mask;

  assign base_word = req.addr >> OFFSET_BITS;
  assign next_word = base_word + addr_t'(1);
  assign offset    = req.addr[OFFSET_BITS-1:0];
  assign wbytes    = req.wdata;

  // Lanes below the offset hold the bytes that spill into the next word
  always_comb begin
    for (int k = 0; k < N_LANES; k++) begin
      if (lane_idx_t'(k) < offset) begin
        lane_addr[k] = next_word;
      end else begin
        lane_addr[k] = base_word;
      end
    end
  end

  // Data byte i lands on lane (offset + i) mod 4
  // so lane k takes byte (k - offset) mod 4
  always_comb begin
    lane_idx_t src;
    src = '0;
    for (int k = 0; k < N_LANES; k++) begin
      src           = lane_idx_t'(k) - offset;
      lane_wdata[k] = wbytes[src];
    end
  end

  // Number of bytes covered by the store kind, starting at lane 0
  always_comb begin
    case (req.kind)
      store_byte: begin
        kind_mask = 4'b0001;
      end
      store_half: begin
        kind_mask = 4'b0011;
      end
      store_word: begin
        kind_mask = 4'b1111;
      end
      default: begin
        kind_mask = 4'b0000;
      end
    endcase
  end

  // Move the mask to the offset
  // A halfword at offset 3 wraps into lanes 3 and 0
  always_comb begin
    if (req.en) begin
      we_mask = rotl_mask(kind_mask, offset);
    end else begin
      we_mask = '0;
    end
  end

  // Pack each lane request
  always_comb begin
    for (int k = 0; k < N_LANES; k++) begin
      lanes[k].word_addr = lane_addr[k];
      lanes[k].wdata     = lane_wdata[k];
      lanes[k].we        = we_mask[k];
    end
  end

endmodule

// ==== logic/read_align.sv ====
`timescale 1ns/100ps

module read_align
  import mem_pkg::*;
(
  input  logic                 clk_1,
  input  logic                 rst_n_sync,
  input  logic                 en,
  input  lane_idx_t            offset,
  input  byte_t [N_LANES-1:0]  lane_data,
  output word_t                rdata
);

  // Offset of the request whose data the lanes are presenting now
  lane_idx_t offset_q;

  // Bytes of the aligned result, byte 0 in the low bits
  byte_t [N_LANES-1:0] rbytes;

  // Loads together with the lane read registers, so it tracks the same request
  always_ff @(posedge clk_1 or negedge rst_n_sync) begin
    if (!rst_n_sync) begin
      offset_q <= '0;
    end else if (en) begin
      offset_q <= offset;
    end
  end

  // Byte i of the result sits on lane (offset + i) mod 4
  always_comb begin
    lane_idx_t src;
    src = '0;
    for (int i = 0; i < N_LANES; i++) begin
      src       = offset_q + lane_idx_t'(i);
      rbytes[i] = lane_data[src];
    end
  end

  assign rdata = rbytes;

endmodule

// ==== logic/mem_port.sv ====
`timescale 1ns/100ps

module mem_port
  import mem_pkg::*;
#(
  parameter int WORD_ADDR_BITS = 10
) (
  input  logic     clk_1,
  input  logic     rst_n_sync,
  input  mem_req_t req,
  output word_t    rdata
);

  // One request per lane after address split and data rotation
  lane_req_t [N_LANES-1:0] lanes;

  // Raw read bytes, lane k from bank k
  byte_t [N_LANES-1:0] lane_rdata;

  // Byte offset of the current request
  lane_idx_t offset;

  assign offset = req.addr[OFFSET_BITS-1:0];

  // Address, data and write mask for each bank
  lane_request_gen u_req_gen (
    .req   (req),
    .lanes (lanes)
  );

  // Four byte-wide banks
  // All banks read on every enabled edge, writes follow the mask
  for (genvar k = 0; k < N_LANES; k++) begin : g_lane
    byte_lane_ram #(
      .WORD_ADDR_BITS (WORD_ADDR_BITS)
    ) u_ram (
      .clk_1 (clk_1),
      .en    (req.en),
      .req   (lanes[k]),
      .rdata (lane_rdata[k])
    );
  end

  // Put the bytes back in address order one cycle later
  read_align u_align (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .en         (req.en),
    .offset     (offset),
    .lane_data  (lane_rdata),
    .rdata      (rdata)
  );

endmodule

// ==== logic/mem_interface.sv ====
`timescale 1ns/100ps

module mem_interface
  import mem_pkg::*;
#(
  parameter int IMEM_WORD_ADDR_BITS = 10,
  parameter int DMEM_WORD_ADDR_BITS = 10
) (
  input  logic     clk_1,
  input  logic     rst_n_sync,
  input  mem_req_t imem_req,
  input  mem_req_t dmem_req,
  output word_t    imem_rdata,
  output word_t    dmem_rdata
);

  // Instruction port
  // Handles unaligned fetches of compressed instructions
  mem_port #(
    .WORD_ADDR_BITS (IMEM_WORD_ADDR_BITS)
  ) u_imem (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .req        (imem_req),
    .rdata      (imem_rdata)
  );

  // Data port, separate storage from the instruction port
  mem_port #(
    .WORD_ADDR_BITS (DMEM_WORD_ADDR_BITS)
  ) u_dmem (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .req        (dmem_req),
    .rdata      (dmem_rdata)
  );

endmodule

// ==== tests/mem_interface_sva.sv ====
`timescale 1ns/100ps

module lane_req_sva
  import mem_pkg::*;
(
  input logic                    clk_1,
  input logic                    rst_n_sync,
  input mem_req_t                req,
  input lane_req_t [N_LANES-1:0] lanes
);

  logic [N_LANES-1:0] we_mask;
  logic               addr_ok;
  lane_idx_t          offset;
  addr_t              base_word;

  assign offset    = req.addr[OFFSET_BITS-1:0];
  assign base_word = req.addr >> OFFSET_BITS;

  always_comb begin
    for (int k = 0; k < N_LANES; k++) begin
      we_mask[k] = lanes[k].we;
    end
  end

  // Lanes below the offset point at the following word
  always_comb begin
    addr_ok = 1'b1;
    for (int k = 0; k < N_LANES; k++) begin
      if (lane_idx_t'(k) < offset) begin
        if (lanes[k].word_addr != base_word + addr_t'(1)) begin
          addr_ok = 1'b0;
        end
      end else if (lanes[k].word_addr != base_word) begin
        addr_ok = 1'b0;
      end
    end
  end

  idle_no_write: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    !req.en |-> (we_mask == '0))
    else $error("Lane write enable set while the port is idle");

  byte_one_lane: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    (req.en && req.kind == store_byte) |-> $onehot(we_mask))
    else $error("Byte store does not write exactly one lane");

  half_two_lanes: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    (req.en && req.kind == store_half) |->
      (we_mask inside {4'b0011, 4'b0110, 4'b1100, 4'b1001}))
    else $error("Halfword store does not write two adjacent lanes");

  word_lane_addr: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    (req.en && req.kind == store_word) |-> addr_ok)
    else $error("Word store lane addresses do not follow the byte offset");

endmodule

// Watch the lane requests that lane_request_gen drives in every port
bind mem_port lane_req_sva u_lane_req_sva (
  .clk_1      (clk_1),
  .rst_n_sync (rst_n_sync),
  .req        (req),
  .lanes      (lanes)
);

// ==== tests/tb_mem_interface.sv ====
`timescale 1ns/100ps

module tb_mem_interface
  import mem_pkg::*;
();

  localparam int  WORD_BITS  = 6;
  localparam int  BYTE_BITS  = WORD_BITS + OFFSET_BITS;
  localparam int  BYTES      = 1 << BYTE_BITS;
  localparam time CLK_PERIOD = 20;

  logic     clk_1;
  logic     rst_n_sync;
  mem_req_t imem_req;
  mem_req_t dmem_req;
  word_t    imem_rdata;
  word_t    dmem_rdata;

  // Byte-array model, index 0 is the instruction port
  byte_t model_mem [2][BYTES];
  word_t exp_i;
  word_t exp_d;
  logic  armed_i;
  logic  armed_d;
  logic  checking;
  int    mismatch_count;
  int    timeout_count;

  mem_interface #(
    .IMEM_WORD_ADDR_BITS (WORD_BITS),
    .DMEM_WORD_ADDR_BITS (WORD_BITS)
  ) dut0 (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .imem_req   (imem_req),
    .dmem_req   (dmem_req),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata)
  );

  always #(CLK_PERIOD / 2) clk_1 = ~clk_1;

  function automatic word_t read_model(input int p, input addr_t a);
    word_t                w;
    logic [BYTE_BITS-1:0] bidx;
    w = '0;
    for (int i = 0; i < N_LANES; i++) begin
      bidx         = BYTE_BITS'(a + addr_t'(i));
      w[8*i +: 8]  = model_mem[p][bidx];
    end
    return w;
  endfunction

  function automatic void write_model(input int p, input mem_req_t r);
    int                   n;
    logic [BYTE_BITS-1:0] bidx;
    case (r.kind)
      store_byte: n = 1;
      store_half: n = 2;
      store_word: n = 4;
      default:    n = 0;
    endcase
    for (int i = 0; i < n; i++) begin
      bidx              = BYTE_BITS'(r.addr + addr_t'(i));
      model_mem[p][bidx] = r.wdata[8*i +: 8];
    end
  endfunction

  // Expected word is taken before the store of the same edge lands
  always @(posedge clk_1) begin
    if (imem_req.en) begin
      exp_i   <= read_model(0, imem_req.addr);
      armed_i <= checking;
      write_model(0, imem_req);
    end
    if (dmem_req.en) begin
      exp_d   <= read_model(1, dmem_req.addr);
      armed_d <= checking;
      write_model(1, dmem_req);
    end
  end

  // Also covers hold while en is low, since the expected word holds too
  imem_rdata_check: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    armed_i |-> (imem_rdata == exp_i))
    else begin
      $display("MISMATCH %0t imem rdata %h expected %h", $time,
               $sampled(imem_rdata), $sampled(exp_i));
      mismatch_count++;
    end

  dmem_rdata_check: assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    armed_d |-> (dmem_rdata == exp_d))
    else begin
      $display("MISMATCH %0t dmem rdata %h expected %h", $time,
               $sampled(dmem_rdata), $sampled(exp_d));
      mismatch_count++;
    end

  // Each falling edge must arrive within two clock periods
  task automatic wait_falls(input int n);
    int seen;
    bit fell;
    seen = 0;
    while (seen < n) begin
      fell = 1'b0;
      fork
        begin
          @(negedge clk_1);
          fell = 1'b1;
        end
        begin
          #(2 * CLK_PERIOD);
        end
      join_any
      disable fork;
      if (fell) begin
        seen++;
      end else begin
        $display("Timeout while waiting for %0d falling clock edges", n);
        timeout_count++;
        seen = n;
      end
    end
  endtask

  function automatic mem_req_t make_req(input logic en, input store_kind_e kind,
                                        input addr_t a, input word_t d);
    mem_req_t r;
    r.en    = en;
    r.kind  = kind;
    r.addr  = a;
    r.wdata = d;
    return r;
  endfunction

  // New requests change at the falling edge, one per cycle
  task automatic drive_pair(input mem_req_t i_r, input mem_req_t d_r);
    wait_falls(1);
    imem_req = i_r;
    dmem_req = d_r;
  endtask

  task automatic issue(input int port, input store_kind_e kind, input addr_t a,
                       input word_t d);
    mem_req_t r;
    r = make_req(1'b1, kind, a, d);
    if (port == 0) begin
      drive_pair(r, '0);
    end else begin
      drive_pair('0, r);
    end
  endtask

  // Byte value follows the byte address, with a different pattern per port
  function automatic word_t fill_word(input int p, input addr_t a);
    word_t w;
    w = '0;
    for (int i = 0; i < N_LANES; i++) begin
      w[8*i +: 8] = 8'(a + addr_t'(i)) ^ ((p == 0) ? 8'h00 : 8'h5a);
    end
    return w;
  endfunction

  function automatic mem_req_t random_req();
    mem_req_t r;
    int       pick;
    pick    = $urandom_range(0, 5);
    r.en    = ($urandom_range(0, 3) != 0);
    r.addr  = addr_t'($urandom());
    r.wdata = word_t'($urandom());
    case (pick)
      0:       r.kind = store_none;
      1:       r.kind = store_byte;
      2:       r.kind = store_half;
      3, 4:    r.kind = store_word;
      default: r.kind = store_kind_e'(3'($urandom_range(5, 7)));
    endcase
    return r;
  endfunction

  initial begin
    addr_t a;
    void'($urandom(95766));
    clk_1          = 1'b0;
    rst_n_sync     = 1'b0;
    imem_req       = '0;
    dmem_req       = '0;
    exp_i          = '0;
    exp_d          = '0;
    armed_i        = 1'b0;
    armed_d        = 1'b0;
    checking       = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;

    wait_falls(3);
    rst_n_sync = 1'b1;

    // Known contents everywhere before any check
    for (int w = 0; w < BYTES / N_LANES; w++) begin
      a = addr_t'(w * N_LANES);
      drive_pair(make_req(1'b1, store_word, a, fill_word(0, a)),
                 make_req(1'b1, store_word, a, fill_word(1, a)));
    end
    drive_pair('0, '0);
    checking = 1'b1;

    // Aligned store and read back
    for (int p = 0; p < 2; p++) begin
      issue(p, store_word, 32'd8, word_t'($urandom()));
      issue(p, store_none, 32'd8, '0);
    end

    // Byte and halfword stores at every offset
    for (int off = 0; off < N_LANES; off++) begin
      issue(1, store_byte, addr_t'(16 + off), word_t'($urandom()));
      issue(1, store_none, 32'd16, '0);
      issue(1, store_none, 32'd20, '0);
      issue(1, store_half, addr_t'(32 + off), word_t'($urandom()));
      issue(1, store_none, 32'd32, '0);
      issue(1, store_none, 32'd36, '0);
    end

    // Unaligned reads spanning two words
    for (int off = 1; off < N_LANES; off++) begin
      issue(0, store_none, addr_t'(40 + off), '0);
      issue(1, store_none, addr_t'(40 + off), '0);
    end

    // Word store at the top of memory wraps into word 0
    for (int p = 0; p < 2; p++) begin
      issue(p, store_word, addr_t'(BYTES - 1), word_t'($urandom()));
      issue(p, store_none, addr_t'(BYTES - 1), '0);
      issue(p, store_none, 32'd0, '0);
    end

    // Same address on both ports in the same cycle
    drive_pair(make_req(1'b1, store_word, 32'd64, 32'h1122_3344),
               make_req(1'b1, store_word, 32'd64, 32'hAABB_CCDD));
    drive_pair(make_req(1'b1, store_none, 32'd64, '0),
               make_req(1'b1, store_none, 32'd64, '0));

    // rdata must hold across idle cycles
    repeat (3) drive_pair('0, '0);

    for (int n = 0; n < 80; n++) begin
      drive_pair(random_req(), random_req());
    end

    drive_pair('0, '0);
    wait_falls(3);

    $display("Error counts: mismatches %0d, timeouts %0d", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== all.f ====
logic/mem_pkg.sv
logic/byte_lane_ram.sv
logic/lane_request_gen.sv
logic/read_align.sv
logic/mem_port.sv
logic/mem_interface.sv
tests/mem_interface_sva.sv
tests/tb_mem_interface.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mem_interface \
  --Mdir obj_dir \
  -o tb_mem_interface \
  -f all.f

# A failing simulator exit is judged by the output search below
out=$(./obj_dir/tb_mem_interface 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
